// File: src/cpu_pkg.sv
package cpu_pkg;

  ////////////////////
  // Widths
  ////////////////////
  localparam int WORD_W   = 16;  // Data path and address width
  localparam int REG_ID_W = 4;   // Register number width
  localparam int FLAG_W   = 3;   // Z, N and V
  localparam int NUM_REGS = 16;  // Architectural registers r0 to r15

  typedef logic [WORD_W-1:0]   word_t;    // Register value or ALU operand
  typedef logic [WORD_W-1:0]   addr_t;    // Instruction address
  typedef logic [WORD_W-1:0]   instr_t;   // Raw instruction word
  typedef logic [REG_ID_W-1:0] reg_id_t;  // Register number
  typedef logic [3:0]          alu_op_t;  // ALU operation, same encoding as the opcode
  typedef logic [FLAG_W-1:0]   flags_t;   // Condition flags

  ////////////////////
  // Instruction fields
  ////////////////////
  localparam int OPC_MSB  = 15;
  localparam int OPC_LSB  = 12;
  localparam int RD_MSB   = 11;
  localparam int RD_LSB   = 8;
  localparam int RS_MSB   = 7;
  localparam int RS_LSB   = 4;
  localparam int RT_MSB   = 3;   // Also the 4-bit immediate
  localparam int RT_LSB   = 0;
  localparam int IMM8_MSB = 7;   // LLI immediate overlaps rs and rt
  localparam int IMM8_LSB = 0;

  // Bit positions inside flags_t
  localparam int FLAG_Z = 2;
  localparam int FLAG_N = 1;
  localparam int FLAG_V = 0;

  ////////////////////
  // Opcodes
  ////////////////////
  localparam alu_op_t OP_ADD  = 4'h0;
  localparam alu_op_t OP_SUB  = 4'h1;
  localparam alu_op_t OP_XOR  = 4'h2;
  localparam alu_op_t OP_AND  = 4'h3;
  localparam alu_op_t OP_OR   = 4'h4;
  localparam alu_op_t OP_SLL  = 4'h5;
  localparam alu_op_t OP_SRL  = 4'h6;
  localparam alu_op_t OP_ADDI = 4'h7;
  localparam alu_op_t OP_LLI  = 4'h8;
  localparam alu_op_t OP_PCS  = 4'h9;
  localparam alu_op_t OP_HLT  = 4'hF;  // Opcodes 10 to 14 decode as no-ops

endpackage

// File: src/id_ex_if.sv
`timescale 1ns/10ps

interface id_ex_if import cpu_pkg::*; ();

  logic    valid;      // Bundle holds a live instruction
  addr_t   pc_next;    // Address of the following instruction, used by PCS
  reg_id_t src1;       // Source register numbers for forwarding
  reg_id_t src2;       // Zero when the operand is not a register
  word_t   alu_in1;
  word_t   alu_in2;
  word_t   alu_imm;    // Immediate already extended to a full word
  alu_op_t alu_op;
  logic    alu_src;    // Take alu_imm instead of alu_in2
  logic    z_en;
  logic    nv_en;
  reg_id_t rd;
  logic    reg_write;
  logic    halt;
  logic    pcs;

  modport sender (
    output valid, pc_next, src1, src2, alu_in1, alu_in2, alu_imm,
           alu_op, alu_src, z_en, nv_en, rd, reg_write, halt, pcs
  );

  modport receiver (
    input valid, pc_next, src1, src2, alu_in1, alu_in2, alu_imm,
          alu_op, alu_src, z_en, nv_en, rd, reg_write, halt, pcs
  );

endinterface

// File: src/wb_if.sv
`timescale 1ns/10ps

interface wb_if import cpu_pkg::*; ();

  logic    wr_en;    // EX/WB holds a result that goes to a register
  reg_id_t wr_rd;
  word_t   wr_data;
  logic    halted;   // Sticky once a HLT has executed

  modport sender (output wr_en, wr_rd, wr_data, halted);

  // Register file write port
  modport receiver (input wr_en, wr_rd, wr_data);

  // Decoder only needs to know when to stop issuing
  modport halt_reader (input halted);

endinterface

// File: src/register_file.sv
`timescale 1ns/10ps

module register_file import cpu_pkg::*; (
  input  logic    clk,
  input  logic    arst_n,
  input  reg_id_t rs_addr,
  input  reg_id_t rt_addr,
  output word_t   rs_data,
  output word_t   rt_data,
  wb_if.receiver  wb
);

  word_t regs [NUM_REGS];  // r0 is never written so it stays zero
  logic  rs_hit;           // Read address matches the live write port
  logic  rt_hit;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.wr_en && (wb.wr_rd != '0)) begin
      regs[wb.wr_rd] <= wb.wr_data;  // Writes to r0 are dropped here
    end
  end

  // The EX/WB value counts as written in the cycle it is presented
  // This lets an instruction two behind see it without a stall
  assign rs_hit = wb.wr_en && (wb.wr_rd == rs_addr);
  assign rt_hit = wb.wr_en && (wb.wr_rd == rt_addr);

  assign rs_data = (rs_addr == '0) ? '0 :
                   rs_hit          ? wb.wr_data :
                                     regs[rs_addr];
  assign rt_data = (rt_addr == '0) ? '0 :
                   rt_hit          ? wb.wr_data :
                                     regs[rt_addr];

endmodule

// File: src/instr_decoder.sv
`timescale 1ns/10ps

module instr_decoder import cpu_pkg::*; (
  input  logic       instr_valid,
  input  instr_t     instr,
  input  addr_t      pc_next,
  output reg_id_t    rs_addr,
  output reg_id_t    rt_addr,
  input  word_t      rs_data,
  input  word_t      rt_data,
  wb_if.halt_reader  wb,
  id_ex_if.sender    dec_bus
);

  alu_op_t    opcode;
  reg_id_t    rd_f;
  reg_id_t    rs_f;
  reg_id_t    rt_f;
  logic [3:0] imm4;       // ADDI offset or shift amount
  logic [7:0] imm8;       // LLI value
  word_t      imm;
  logic       alu_src;
  logic       z_en;
  logic       nv_en;
  logic       uses_rs;    // Operand 1 comes from a register
  logic       uses_rt;    // Operand 2 comes from a register
  logic       writes_rd;  // Opcode produces a register result

  ////////////////////
  // Field split
  ////////////////////
  assign opcode = instr[OPC_MSB:OPC_LSB];
  assign rd_f   = instr[RD_MSB:RD_LSB];
  assign rs_f   = instr[RS_MSB:RS_LSB];
  assign rt_f   = instr[RT_MSB:RT_LSB];
  assign imm4   = instr[RT_MSB:RT_LSB];
  assign imm8   = instr[IMM8_MSB:IMM8_LSB];

  assign rs_addr = rs_f;  // Register file reads are asynchronous
  assign rt_addr = rt_f;

  always_comb begin
    imm       = '0;
    alu_src   = 1'b0;
    z_en      = 1'b0;
    nv_en     = 1'b0;
    uses_rs   = 1'b0;
    uses_rt   = 1'b0;
    writes_rd = 1'b0;
    case (opcode)
      OP_ADD, OP_SUB: begin
        uses_rs   = 1'b1;
        uses_rt   = 1'b1;
        writes_rd = 1'b1;
        z_en      = 1'b1;
        nv_en     = 1'b1;
      end
      OP_XOR, OP_AND, OP_OR: begin
        uses_rs   = 1'b1;
        uses_rt   = 1'b1;
        writes_rd = 1'b1;
        z_en      = 1'b1;  // Logic ops leave N and V alone
      end
      OP_SLL, OP_SRL: begin
        uses_rs   = 1'b1;
        writes_rd = 1'b1;
        z_en      = 1'b1;
        alu_src   = 1'b1;
        imm       = {{(WORD_W-4){1'b0}}, imm4};
      end
      OP_ADDI: begin
        uses_rs   = 1'b1;
        writes_rd = 1'b1;
        z_en      = 1'b1;
        nv_en     = 1'b1;
        alu_src   = 1'b1;
        imm       = {{(WORD_W-4){imm4[3]}}, imm4};  // Signed offset
      end
      OP_LLI: begin
        writes_rd = 1'b1;
        alu_src   = 1'b1;
        imm       = {{(WORD_W-8){1'b0}}, imm8};
      end
      OP_PCS:  writes_rd = 1'b1;
      default: writes_rd = 1'b0;  // HLT and the unused opcodes
    endcase
  end

  ////////////////////
  // Bundle out
  ////////////////////
  assign dec_bus.valid     = instr_valid & ~wb.halted;  // Nothing issues after HLT
  assign dec_bus.pc_next   = pc_next;
  assign dec_bus.src1      = uses_rs ? rs_f : '0;       // Zero disables forwarding
  assign dec_bus.src2      = uses_rt ? rt_f : '0;
  assign dec_bus.alu_in1   = rs_data;
  assign dec_bus.alu_in2   = rt_data;
  assign dec_bus.alu_imm   = imm;
  assign dec_bus.alu_op    = opcode;
  assign dec_bus.alu_src   = alu_src;
  assign dec_bus.z_en      = z_en;
  assign dec_bus.nv_en     = nv_en;
  assign dec_bus.rd        = rd_f;
  assign dec_bus.reg_write = writes_rd & (rd_f != '0);  // r0 results are discarded
  assign dec_bus.halt      = (opcode == OP_HLT);
  assign dec_bus.pcs       = (opcode == OP_PCS);

endmodule

// File: src/id_ex_pipe_reg.sv
`timescale 1ns/10ps

module id_ex_pipe_reg import cpu_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      stall,
  input  logic      flush,
  id_ex_if.receiver dec_bus,
  id_ex_if.sender   ex_bus
);

  logic valid_q;  // Entry holds an instruction
  logic fresh_q;  // Entry was loaded at the last edge and has not been seen yet

  ////////////////////
  // Control state
  ////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
      fresh_q <= 1'b0;
    end else begin
      if (flush) begin
        valid_q <= 1'b0;                 // Flush wins over stall
      end else if (!stall) begin
        valid_q <= dec_bus.valid;
      end
      fresh_q <= ~stall;                 // A held entry goes stale after one cycle
    end
  end

  assign ex_bus.valid = valid_q & fresh_q;  // Execute sees each entry once

  // Payload follows the decoder unless it is held or flushed
  always_ff @(posedge clk) begin
    if (flush) begin
      ex_bus.pc_next   <= '0;
      ex_bus.src1      <= '0;
      ex_bus.src2      <= '0;
      ex_bus.alu_in1   <= '0;
      ex_bus.alu_in2   <= '0;
      ex_bus.alu_imm   <= '0;
      ex_bus.alu_op    <= '0;
      ex_bus.alu_src   <= 1'b0;
      ex_bus.z_en      <= 1'b0;
      ex_bus.nv_en     <= 1'b0;
      ex_bus.rd        <= '0;
      ex_bus.reg_write <= 1'b0;
      ex_bus.halt      <= 1'b0;
      ex_bus.pcs       <= 1'b0;
    end else if (!stall) begin
      ex_bus.pc_next   <= dec_bus.pc_next;
      ex_bus.src1      <= dec_bus.src1;
      ex_bus.src2      <= dec_bus.src2;
      ex_bus.alu_in1   <= dec_bus.alu_in1;
      ex_bus.alu_in2   <= dec_bus.alu_in2;
      ex_bus.alu_imm   <= dec_bus.alu_imm;
      ex_bus.alu_op    <= dec_bus.alu_op;
      ex_bus.alu_src   <= dec_bus.alu_src;
      ex_bus.z_en      <= dec_bus.z_en;
      ex_bus.nv_en     <= dec_bus.nv_en;
      ex_bus.rd        <= dec_bus.rd;
      ex_bus.reg_write <= dec_bus.reg_write;
      ex_bus.halt      <= dec_bus.halt;
      ex_bus.pcs       <= dec_bus.pcs;
    end
  end

endmodule

// File: src/execute_stage.sv
`timescale 1ns/10ps

module execute_stage import cpu_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  id_ex_if.receiver ex_bus,
  wb_if.sender      wb,
  output flags_t    flags
);

  logic    issue;      // Live instruction and the core is not halted
  logic    fwd1;
  logic    fwd2;
  word_t   op1;
  word_t   op2_reg;    // Operand 2 after forwarding
  word_t   op2;
  word_t   alu_res;
  logic    ovf;        // Signed overflow of add or subtract
  logic    wr_en_q;
  reg_id_t wr_rd_q;
  word_t   wr_data_q;
  flags_t  flags_q;
  logic    halted_q;

  assign issue = ex_bus.valid & ~halted_q;

  ////////////////////
  // Forwarding
  ////////////////////
  assign fwd1 = wr_en_q && (ex_bus.src1 != '0) && (ex_bus.src1 == wr_rd_q);
  assign fwd2 = wr_en_q && (ex_bus.src2 != '0) && (ex_bus.src2 == wr_rd_q);

  assign op1     = fwd1 ? wr_data_q : ex_bus.alu_in1;
  assign op2_reg = fwd2 ? wr_data_q : ex_bus.alu_in2;
  assign op2     = ex_bus.alu_src ? ex_bus.alu_imm : op2_reg;

  always_comb begin
    alu_res = '0;
    ovf     = 1'b0;
    case (ex_bus.alu_op)
      OP_ADD, OP_ADDI: begin
        alu_res = op1 + op2;
        ovf     = (op1[WORD_W-1] == op2[WORD_W-1]) && (alu_res[WORD_W-1] != op1[WORD_W-1]);
      end
      OP_SUB: begin
        alu_res = op1 - op2;
        ovf     = (op1[WORD_W-1] != op2[WORD_W-1]) && (alu_res[WORD_W-1] != op1[WORD_W-1]);
      end
      OP_XOR:  alu_res = op1 ^ op2;
      OP_AND:  alu_res = op1 & op2;
      OP_OR:   alu_res = op1 | op2;
      OP_SLL:  alu_res = op1 << op2[$clog2(WORD_W)-1:0];
      OP_SRL:  alu_res = op1 >> op2[$clog2(WORD_W)-1:0];  // Logical so zeros shift in
      OP_LLI:  alu_res = op2;                             // Immediate straight through
      default: alu_res = '0;
    endcase
    if (ex_bus.pcs) begin
      alu_res = ex_bus.pc_next;  // PCS returns the address of the following instruction
    end
  end

  ////////////////////
  // EX/WB register
  ////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_en_q   <= 1'b0;
      wr_rd_q   <= '0;
      wr_data_q <= '0;
      flags_q   <= '0;
      halted_q  <= 1'b0;
    end else begin
      wr_en_q  <= issue & ex_bus.reg_write;
      halted_q <= halted_q | (issue & ex_bus.halt);  // Stays set until reset
      if (issue && ex_bus.reg_write) begin
        wr_rd_q   <= ex_bus.rd;                      // Last result is held otherwise
        wr_data_q <= alu_res;
      end
      if (issue && ex_bus.z_en) begin
        flags_q[FLAG_Z] <= (alu_res == '0);
      end
      if (issue && ex_bus.nv_en) begin
        flags_q[FLAG_N] <= alu_res[WORD_W-1];
        flags_q[FLAG_V] <= ovf;
      end
    end
  end

  assign wb.wr_en   = wr_en_q;
  assign wb.wr_rd   = wr_rd_q;
  assign wb.wr_data = wr_data_q;
  assign wb.halted  = halted_q;
  assign flags      = flags_q;

endmodule

// File: src/decode_execute_top.sv
`timescale 1ns/10ps

module decode_execute_top import cpu_pkg::*; (
  input  logic    clk,
  input  logic    arst_n,
  input  logic    instr_valid,
  input  instr_t  instr,
  input  addr_t   pc_next,
  input  logic    stall,
  input  logic    flush,
  output logic    result_valid,
  output reg_id_t result_rd,
  output word_t   result,
  output flags_t  flags,
  output logic    halted
);

  reg_id_t rs_addr;
  reg_id_t rt_addr;
  word_t   rs_data;
  word_t   rt_data;

  id_ex_if dec_bus ();  // Decoder to pipe register
  id_ex_if ex_bus ();   // Pipe register to execute
  wb_if    wb ();       // EX/WB back to decode and the register file

  ////////////////////
  // Decode
  ////////////////////
  register_file register_file_i (
    .clk     (clk),
    .arst_n  (arst_n),
    .rs_addr (rs_addr),
    .rt_addr (rt_addr),
    .rs_data (rs_data),
    .rt_data (rt_data),
    .wb      (wb.receiver)
  );

  instr_decoder instr_decoder_i (
    .instr_valid (instr_valid),
    .instr       (instr),
    .pc_next     (pc_next),
    .rs_addr     (rs_addr),
    .rt_addr     (rt_addr),
    .rs_data     (rs_data),
    .rt_data     (rt_data),
    .wb          (wb.halt_reader),
    .dec_bus     (dec_bus.sender)
  );

  ////////////////////
  // Execute
  ////////////////////
  id_ex_pipe_reg id_ex_pipe_reg_i (
    .clk     (clk),
    .arst_n  (arst_n),
    .stall   (stall),
    .flush   (flush),
    .dec_bus (dec_bus.receiver),
    .ex_bus  (ex_bus.sender)
  );

  execute_stage execute_stage_i (
    .clk    (clk),
    .arst_n (arst_n),
    .ex_bus (ex_bus.receiver),
    .wb     (wb.sender),
    .flags  (flags)
  );

  // Results leave straight from the EX/WB register
  assign result_valid = wb.wr_en;
  assign result_rd    = wb.wr_rd;
  assign result       = wb.wr_data;
  assign halted       = wb.halted;

endmodule

// File: tb/tb_decode_execute.sv
`timescale 1ns/10ps

module tb_decode_execute import cpu_pkg::*; ();

  localparam int    RESET_TIMEOUT   = 20;    // Cycles allowed for reset release
  localparam int    MAX_TRACE_LINES = 1000;  // Bounds the file read loop
  localparam string TRACE_FILE      = "tb/decode_execute_trace.txt";

  // One trace line holds the inputs and then the outputs expected two edges later
  typedef struct packed {
    logic    stall;
    logic    flush;
    logic    instr_valid;
    instr_t  instr;
    addr_t   pc_next;
    logic    exp_valid;
    reg_id_t exp_rd;
    word_t   exp_result;
    flags_t  exp_flags;
    logic    exp_halted;
  } trace_row_t;

  logic    clk = 1'b0;
  logic    arst_n;
  logic    instr_valid;
  instr_t  instr;
  addr_t   pc_next;
  logic    stall;
  logic    flush;
  logic    result_valid;
  reg_id_t result_rd;
  word_t   result;
  flags_t  flags;
  logic    halted;

  trace_row_t rows [$];      // Whole trace is read before reset is released
  int         mismatch_cnt;
  int         other_err_cnt;

  decode_execute_top decode_execute_top_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .pc_next      (pc_next),
    .stall        (stall),
    .flush        (flush),
    .result_valid (result_valid),
    .result_rd    (result_rd),
    .result       (result),
    .flags        (flags),
    .halted       (halted)
  );

  always #2 clk = ~clk;  // 4 ns period

  // Reset is released on a falling edge after two cycles
  initial begin
    arst_n = 1'b0;
    repeat (2) @(negedge clk);
    arst_n = 1'b1;
  end

  ////////////////////
  // Compare tasks
  ////////////////////
  task automatic check_word(input word_t exp_val, input word_t act_val, input string label);
    if (act_val !== exp_val) begin
      mismatch_cnt++;
      $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, label, exp_val, act_val);
    end
  endtask

  task automatic check_reg_id(input reg_id_t exp_val, input reg_id_t act_val,
                              input string label);
    if (act_val !== exp_val) begin
      mismatch_cnt++;
      $display("CHECK FAILED at %0t: %s expected r%0d, got r%0d", $time, label,
               exp_val, act_val);
    end
  endtask

  task automatic check_flags(input flags_t exp_val, input flags_t act_val, input string label);
    if (act_val !== exp_val) begin
      mismatch_cnt++;  // Shown as ZNV bits
      $display("CHECK FAILED at %0t: %s expected %b, got %b", $time, label, exp_val, act_val);
    end
  endtask

  task automatic check_bit(input logic exp_val, input logic act_val, input string label);
    if (act_val !== exp_val) begin
      mismatch_cnt++;
      $display("CHECK FAILED at %0t: %s expected %b, got %b", $time, label, exp_val, act_val);
    end
  endtask

  ////////////////////
  // Trace handling
  ////////////////////
  task automatic load_trace();
    int         fd;
    int         n_read;
    int         n_fields;
    int         line_no;
    string      line;
    logic       v_stall;
    logic       v_flush;
    logic       v_iv;
    instr_t     v_instr;
    addr_t      v_pc;
    logic       v_rv;
    reg_id_t    v_rd;
    word_t      v_res;
    flags_t     v_flags;
    logic       v_halt;
    trace_row_t row;
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      other_err_cnt++;
      $display("Could not open the trace file %s", TRACE_FILE);
      return;
    end
    line_no = 0;
    n_read  = 1;
    while (n_read > 0 && line_no < MAX_TRACE_LINES) begin
      n_read = $fgets(line, fd);
      line_no++;
      // Lines starting with a hash and blank lines carry no stimulus
      if (n_read > 0 && line.getc(0) != "#" && line.getc(0) != "\n") begin
        n_fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", v_stall, v_flush, v_iv,
                           v_instr, v_pc, v_rv, v_rd, v_res, v_flags, v_halt);
        if (n_fields != 10) begin
          other_err_cnt++;
          $display("Trace line %0d could not be parsed, found %0d of 10 fields",
                   line_no, n_fields);
        end else begin
          row = '{v_stall, v_flush, v_iv, v_instr, v_pc, v_rv, v_rd, v_res, v_flags, v_halt};
          rows.push_back(row);
        end
      end
    end
    $fclose(fd);
    if (rows.size() == 0) begin
      other_err_cnt++;
      $display("The trace file holds no stimulus lines");
    end
  endtask

  task automatic drive_row(input trace_row_t row);
    stall       = row.stall;
    flush       = row.flush;
    instr_valid = row.instr_valid;
    instr       = row.instr;
    pc_next     = row.pc_next;
  endtask

  task automatic drive_idle();
    stall       = 1'b0;
    flush       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    pc_next     = '0;
  endtask

  // rd and result are only meaningful while result_valid is high
  task automatic check_row(input trace_row_t row, input int idx);
    string tag;
    tag = $sformatf("row %0d", idx);
    check_bit(row.exp_valid, result_valid, {tag, " result_valid"});
    if (row.exp_valid) begin
      check_reg_id(row.exp_rd, result_rd, {tag, " result_rd"});
      check_word(row.exp_result, result, {tag, " result"});
    end
    check_flags(row.exp_flags, flags, {tag, " flags"});
    check_bit(row.exp_halted, halted, {tag, " halted"});
  endtask

  ////////////////////
  // Main sequence
  ////////////////////
  initial begin
    int n_rows;
    int waited;
    int idx;
    mismatch_cnt  = 0;
    other_err_cnt = 0;
    drive_idle();
    load_trace();
    n_rows = rows.size();
    waited = 0;
    while (arst_n !== 1'b1 && waited < RESET_TIMEOUT) begin
      @(posedge clk);  // Sampled on the rising edge away from the release
      waited++;
    end
    if (arst_n !== 1'b1) begin
      other_err_cnt++;
      $display("Reset was not released within %0d cycles", RESET_TIMEOUT);
    end else if (other_err_cnt == 0) begin
      @(negedge clk);
      check_bit(1'b0, result_valid, "reset result_valid");
      check_flags('0, flags, "reset flags");
      check_bit(1'b0, halted, "reset halted");
      // Row idx goes in at this falling edge and is checked two falling edges later
      for (idx = 0; idx < n_rows + 2; idx++) begin
        @(negedge clk);
        if (idx >= 2) begin
          check_row(rows[idx-2], idx - 2);
        end
        if (idx < n_rows) begin
          drive_row(rows[idx]);
        end else begin
          drive_idle();
        end
      end
    end
    $display("Mismatches: %0d, other errors: %0d", mismatch_cnt, other_err_cnt);
    if (mismatch_cnt == 0 && other_err_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: tb/decode_execute_trace.txt
# Hex columns: stall flush instr_valid instr pc_next, then expected two edges later
# result_valid result_rd result flags(ZNV) halted; rd and result count only when valid
# Load registers and run the basic ALU operations
0 0 1 8105 1001  1 1 0005 0 0
0 0 1 8203 1002  1 2 0003 0 0
0 0 1 0312 1003  1 3 0008 0 0
0 0 1 1421 1004  1 4 fffe 2 0
0 0 1 2531 1005  1 5 000d 2 0
0 0 1 3652 1006  1 6 0001 2 0
0 0 1 3732 1007  1 7 0000 6 0
0 0 1 4831 1008  1 8 000d 2 0
0 0 1 5914 1009  1 9 0050 2 0
0 0 1 6a92 100a  1 a 0014 2 0
0 0 1 7bad 100b  1 b 0011 0 0
# Build 0x7fff by forwarding, then overflow it with ADD, ADDI and SUB
0 0 1 8c7f 100c  1 c 007f 0 0
0 0 1 5cc8 100d  1 c 7f00 0 0
0 0 1 8dff 100e  1 d 00ff 0 0
0 0 1 4ccd 100f  1 c 7fff 0 0
0 0 1 0ecc 1010  1 e fffe 3 0
0 0 1 7ec1 1011  1 e 8000 3 0
0 0 1 1fee 1012  1 f 0000 4 0
0 0 1 1fc4 1013  1 f 8001 3 0
# Write to r0 gives no result and r0 still reads zero
0 0 1 0012 1014  0 0 0000 0 0
0 0 1 0102 1015  1 1 0003 0 0
# Stall and flush drop the offered instruction
1 0 1 82aa 1016  0 0 0000 0 0
0 1 1 83bb 1017  0 0 0000 0 0
0 0 1 0423 1018  1 4 000b 0 0
# PCS, then HLT stops all later results
0 0 1 9500 1019  1 5 1019 0 0
0 0 1 f000 101a  0 0 0000 0 1
0 0 1 8612 101b  0 0 0000 0 1
0 0 1 0712 101c  0 0 0000 0 1

// File: project.f
src/cpu_pkg.sv
src/id_ex_if.sv
src/wb_if.sv
src/register_file.sv
src/instr_decoder.sv
src/id_ex_pipe_reg.sv
src/execute_stage.sv
src/decode_execute_top.sv
tb/tb_decode_execute.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f project.f --top-module tb_decode_execute -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
  exit 1
fi
exit 0
